// File: fetch_stage.sv
`timescale 1ns/1ns
`include "frontend_macros.svh"

module fetch_stage import frontend_pkg::*; (
    input               clock,
    input               reset,
    // redirect from the branch unit
    input               take_branch,
    input  addr_t       target_pc,
    // dispatch cannot accept this cycle
    input               dis_stall,
    // lookup result for the current pc
    input               cache_valid,
    input  inst_t       cache_inst,
    // lookup address toward the icache
    output addr_t       pc,
    // fetch output toward dispatch
    output logic        if_valid,
    output addr_t       if_pc,
    output addr_t       if_npc,
    output inst_t       if_inst,
    // hint to the predictor
    output logic        fetch_en
);

    // pc being fetched right now
    addr_t pc_reg;
    addr_t next_pc;
    addr_t pc_plus_4;

    assign pc_plus_4 = pc_reg + 32'd4;

    ////////////////////
    // next pc select
    ////////////////////

    // priority: redirect, then hold, then sequential
    always_comb begin
        if (take_branch) begin
            next_pc = target_pc;
        end else if (dis_stall || !cache_valid) begin
            // stall or miss, retry same pc
            next_pc = pc_reg;
        end else begin
            next_pc = pc_plus_4;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_reg <= `RESET_PC;
        end else begin
            pc_reg <= next_pc;
        end
    end

    ////////////////////
    // fetch outputs
    ////////////////////

    assign pc       = pc_reg;
    assign if_valid = cache_valid;
    assign if_pc    = pc_reg;
    // pc + 4 travels with the instruction
    assign if_npc   = pc_plus_4;
    // no stale bits downstream on a miss
    assign if_inst  = cache_valid ? cache_inst : '0;

    // valid fetch not overridden by a redirect
    assign fetch_en = cache_valid && !take_branch;

endmodule

// File: frontend_golden.txt
# command  count-or-target  first-pc  first-inst  (all numbers hex)
# run fetches count instructions, branch redirects, stall holds count cycles then releases
run     00000008  00000000  00000013
stall   00000005  00000020  00080013
run     00000004  00000024  00090013
branch  00000000  00000000  00000013
run     00000006  00000004  00010013
branch  00000200  00000200  00800013
run     00000003  00000204  00810013
branch  00000040  00000040  00100013
run     00000002  00000044  00110013
branch  000000c0  000000c0  00300013
run     00000002  000000c4  00310013
branch  00000140  00000140  00500013
run     00000002  00000144  00510013
branch  00000040  00000040  00100013
run     00000001  00000044  00110013
branch  000000c0  000000c0  00300013
stall   00000003  000000c4  00310013
run     00000004  000000c8  00320013
branch  00001000  00001000  04000013
run     00000005  00001004  04010013
branch  00000000  00000000  00000013
run     00000003  00000004  00010013
branch  0003fff8  0003fff8  fffe0013
run     00000004  0003fffc  ffff0013
stall   00000002  0004000c  00030013
run     00000003  00040010  00040013
branch  00000024  00000024  00090013
run     00000003  00000028  000a0013
branch  00000000  00000000  00000013
run     00000002  00000004  00010013
stall   00000004  0000000c  00030013
run     00000004  00000010  00040013
branch  00000804  00000804  02010013
run     00000002  00000808  02020013
branch  00000840  00000840  02100013
run     00000003  00000844  02110013

// File: frontend_macros.svh
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

////////////////////
// datapath widths
////////////////////

// address and pc width
`define XLEN 32

// pc after reset
`define RESET_PC 32'h0000_0000

////////////////////
// icache geometry
////////////////////

// number of sets, power of two
`define ICACHE_SETS 16

// associativity; 1, 2, 4 or 8 all work
`define ICACHE_WAYS 2

// one line = one memory beat = two instructions
`define LINE_BITS 64

`endif

// File: frontend_pkg.sv
package frontend_pkg;

    `include "frontend_macros.svh"

    ////////////////////
    // address split
    ////////////////////

    // byte offset inside a line
    localparam int OFS_BITS = $clog2(`LINE_BITS / 8);
    localparam int IDX_BITS = $clog2(`ICACHE_SETS);
    // whatever is left above the index
    localparam int TAG_BITS = `XLEN - IDX_BITS - OFS_BITS;

    typedef logic [`XLEN-1:0]       addr_t;
    typedef logic [31:0]            inst_t;
    typedef logic [`LINE_BITS-1:0]  line_t;
    typedef logic [IDX_BITS-1:0]    index_t;
    typedef logic [TAG_BITS-1:0]    tag_t;
    // one bit per way, also used one-hot
    typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

    // set index of a byte address
    function automatic index_t line_index(addr_t a);
        return a[OFS_BITS +: IDX_BITS];
    endfunction

    // tag of a byte address
    function automatic tag_t line_tag(addr_t a);
        return a[`XLEN-1 -: TAG_BITS];
    endfunction

    // rebuild the line-aligned address from tag and index
    function automatic addr_t line_addr(tag_t t, index_t i);
        return {t, i, {OFS_BITS{1'b0}}};
    endfunction

endpackage

// File: frontend_props.sv
`timescale 1ns/1ns

////////////////////
// frontend checks
////////////////////

module frontend_props import frontend_pkg::*; (
    input           clock,
    input           reset,
    input           take_branch,
    input           dis_stall,
    input           if_valid,
    input  addr_t   if_pc,
    input  inst_t   if_inst,
    input           mem_req,
    input           mem_valid
);

    // high from a request until its response
    logic outstanding;

    always_ff @(posedge clock) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (mem_req) begin
            outstanding <= 1'b1;
        end else if (mem_valid) begin
            outstanding <= 1'b0;
        end
    end

    // no second request before the line comes back
    one_request: assert property (
        @(posedge clock) disable iff (reset) mem_req |-> !outstanding
    ) else $error("memory request issued with one already outstanding");

    // nothing stale on the fetch output
    inst_zero: assert property (
        @(posedge clock) disable iff (reset) !if_valid |-> (if_inst == '0)
    ) else $error("if_inst not zero while if_valid is low");

    // stalled valid fetch keeps its pc, a redirect still wins
    stall_hold: assert property (
        @(posedge clock) disable iff (reset)
        (if_valid && dis_stall && !take_branch) |=> $stable(if_pc)
    ) else $error("if_pc changed across a stalled cycle");

endmodule

bind frontend_top frontend_props u_props (
    .clock       (clock),
    .reset       (reset),
    .take_branch (take_branch),
    .dis_stall   (dis_stall),
    .if_valid    (if_valid),
    .if_pc       (if_pc),
    .if_inst     (if_inst),
    .mem_req     (mem_req),
    .mem_valid   (mem_valid)
);

// File: frontend_tb.sv
`timescale 1ns/1ns
`include "frontend_macros.svh"

module frontend_tb import frontend_pkg::*; ();

    // dut inputs
    logic  clock;
    logic  reset;
    logic  take_branch;
    addr_t target_pc;
    logic  dis_stall;
    logic  mem_valid;
    line_t mem_data;
    // dut outputs
    logic  if_valid;
    addr_t if_pc;
    addr_t if_npc;
    inst_t if_inst;
    logic  fetch_en;
    logic  mem_req;
    addr_t mem_addr;

    // error counts, one per process
    int check_errors;
    int monitor_errors = 0;
    int memory_errors = 0;
    int steps;
    bit abort;

    frontend_top UUT (
        .clock       (clock),
        .reset       (reset),
        .take_branch (take_branch),
        .target_pc   (target_pc),
        .dis_stall   (dis_stall),
        .mem_valid   (mem_valid),
        .mem_data    (mem_data),
        .if_valid    (if_valid),
        .if_pc       (if_pc),
        .if_npc      (if_npc),
        .if_inst     (if_inst),
        .fetch_en    (fetch_en),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    ////////////////////
    // memory rule
    ////////////////////

    // upper half is the word number, lower half an addi opcode
    function automatic inst_t expected_inst(addr_t a);
        return {a[17:2], 16'h0013};
    endfunction

    // lower address sits in bits 31:0
    function automatic line_t memory_line(addr_t a);
        return {expected_inst(a + 32'd4), expected_inst(a)};
    endfunction

    // memory model, one request, answers 2 to 6 cycles later
    initial begin
        bit    pending;
        int    wait_left;
        addr_t line_addr_q;
        mem_valid = 1'b0;
        mem_data  = '0;
        pending   = 1'b0;
        wait_left = 0;
        forever begin
            @(negedge clock);
            mem_valid = 1'b0;
            if (pending) begin
                wait_left = wait_left - 1;
                if (wait_left == 0) begin
                    mem_valid = 1'b1;
                    mem_data  = memory_line(line_addr_q);
                    pending   = 1'b0;
                end
            end
            if (mem_req) begin
                if (pending) begin
                    memory_errors++;
                    $display("Error at %0t ns: second memory request while one is pending", $time);
                end
                pending     = 1'b1;
                line_addr_q = mem_addr;
                wait_left   = 2 + int'($urandom % 5);
            end
        end
    end

    // mid-cycle monitor, inputs already settled
    always @(negedge clock) begin
        #5;
        if (!reset) begin
            if (fetch_en !== (if_valid && !take_branch)) begin
                monitor_errors++;
                $display("Fail at %0t ns: fetch_en is %b, expected %b",
                         $time, fetch_en, if_valid && !take_branch);
            end
            if (!if_valid && if_inst !== '0) begin
                monitor_errors++;
                $display("Fail at %0t ns: if_inst is %h, expected %h", $time, if_inst, 32'h0);
            end
            // line aligned requests only
            if (mem_req && mem_addr[2:0] !== 3'b000) begin
                monitor_errors++;
                $display("Fail at %0t ns: mem_addr is %h, expected %h",
                         $time, mem_addr, {mem_addr[31:3], 3'b000});
            end
        end
    end

    ////////////////////
    // step tasks
    ////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        check_errors++;
        $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    endtask

    // new inputs at the falling edge
    task automatic drive_cycle(input logic stall, input logic branch, input addr_t target);
        @(negedge clock);
        dis_stall   = stall;
        take_branch = branch;
        target_pc   = target;
    endtask

    // cycle until if_valid, with stall held at the given level
    task automatic wait_for_valid(input logic stall);
        int waited;
        waited = 0;
        drive_cycle(stall, 1'b0, '0);
        while (!if_valid && !abort) begin
            waited++;
            if (waited > 200) begin
                check_errors++;
                abort = 1'b1;
                $display("Timeout at %0t ns: no valid instruction within 200 cycles", $time);
            end else begin
                drive_cycle(stall, 1'b0, '0);
            end
        end
    endtask

    // delivers count instructions, first one against the golden values
    task automatic run_step(input int count, input addr_t first_pc, input inst_t first_inst);
        addr_t exp_pc;
        inst_t exp_inst;
        int    i;
        for (i = 0; i < count && !abort; i++) begin
            // one word further per delivered instruction
            exp_pc   = first_pc + addr_t'(i * 4);
            exp_inst = (i == 0) ? first_inst : expected_inst(exp_pc);
            wait_for_valid(1'b0);
            if (!abort) begin
                if (if_pc !== exp_pc) report_mismatch("if_pc", if_pc, exp_pc);
                if (if_inst !== exp_inst) report_mismatch("if_inst", if_inst, exp_inst);
                if (if_npc !== exp_pc + 32'd4) report_mismatch("if_npc", if_npc, exp_pc + 32'd4);
            end
        end
    endtask

    // hold the first valid instruction, then let it go
    task automatic stall_step(input int cycles, input addr_t first_pc, input inst_t first_inst);
        int i;
        wait_for_valid(1'b1);
        if (!abort) begin
            if (if_pc !== first_pc) report_mismatch("if_pc", if_pc, first_pc);
            if (if_inst !== first_inst) report_mismatch("if_inst", if_inst, first_inst);
            for (i = 0; i <= cycles; i++) begin
                // last pass releases the stall
                drive_cycle(i == cycles ? 1'b0 : 1'b1, 1'b0, '0);
                if (!if_valid) begin
                    check_errors++;
                    $display("Error at %0t ns: if_valid dropped while stalled", $time);
                end
                if (if_pc !== first_pc) report_mismatch("if_pc", if_pc, first_pc);
                if (if_inst !== first_inst) report_mismatch("if_inst", if_inst, first_inst);
            end
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int          fd;
        int          fields;
        string       cmd;
        string       skip_line;
        logic [31:0] arg;
        addr_t       exp_pc;
        inst_t       exp_inst;
        check_errors   = 0;
        steps          = 0;
        abort          = 1'b0;
        reset          = 1'b1;
        take_branch    = 1'b0;
        target_pc      = '0;
        dis_stall      = 1'b0;
        void'($urandom(77398));
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // state right after reset
        if (if_valid !== 1'b0) report_mismatch("if_valid", {31'b0, if_valid}, 32'h0);
        if (mem_req !== 1'b0) report_mismatch("mem_req", {31'b0, mem_req}, 32'h0);
        if (if_pc !== `RESET_PC) report_mismatch("if_pc", if_pc, `RESET_PC);
        fd = $fopen("frontend_golden.txt", "r");
        if (fd == 0) begin
            check_errors++;
            abort = 1'b1;
            $display("Error: cannot open frontend_golden.txt");
        end
        while (!abort && $fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                fields = $fgets(skip_line, fd);
            end else begin
                fields = $fscanf(fd, "%h %h %h", arg, exp_pc, exp_inst);
                steps++;
                if (fields != 3) begin
                    check_errors++;
                    abort = 1'b1;
                    $display("Error: golden step %0d is missing fields", steps);
                end else if (cmd == "run") begin
                    run_step(int'(arg), exp_pc, exp_inst);
                end else if (cmd == "branch") begin
                    drive_cycle(1'b0, 1'b1, arg);
                    run_step(1, exp_pc, exp_inst);
                end else if (cmd == "stall") begin
                    stall_step(int'(arg), exp_pc, exp_inst);
                end else begin
                    check_errors++;
                    $display("Error: golden step %0d has unknown command %s", steps, cmd);
                end
            end
        end
        if (fd != 0) $fclose(fd);
        if (steps == 0) begin
            check_errors++;
            $display("Error: no steps were read from the golden file");
        end
        $display("errors: checks %0d, monitor %0d, memory %0d (%0d steps)",
                 check_errors, monitor_errors, memory_errors, steps);
        if (check_errors + monitor_errors + memory_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: frontend_top.sv
`timescale 1ns/1ns
`include "frontend_macros.svh"

module frontend_top import frontend_pkg::*; (
    input               clock,
    input               reset,
    // redirect and backpressure
    input               take_branch,
    input  addr_t       target_pc,
    input               dis_stall,
    // memory response
    input               mem_valid,
    input  line_t       mem_data,
    // fetch output
    output logic        if_valid,
    output addr_t       if_pc,
    output addr_t       if_npc,
    output inst_t       if_inst,
    output logic        fetch_en,
    // memory request
    output logic        mem_req,
    output addr_t       mem_addr
);

    // fetch <-> controller
    addr_t pc;
    logic  cache_valid;
    inst_t cache_inst;

    // ways <-> controller
    way_mask_t                  way_hit;
    line_t [`ICACHE_WAYS-1:0]   way_lines;
    way_mask_t                  fill_way;
    index_t                     fill_index;
    tag_t                       fill_tag;
    line_t                      fill_line;

    fetch_stage u_fetch (
        .clock       (clock),
        .reset       (reset),
        .take_branch (take_branch),
        .target_pc   (target_pc),
        .dis_stall   (dis_stall),
        .cache_valid (cache_valid),
        .cache_inst  (cache_inst),
        .pc          (pc),
        .if_valid    (if_valid),
        .if_pc       (if_pc),
        .if_npc      (if_npc),
        .if_inst     (if_inst),
        .fetch_en    (fetch_en)
    );

    ////////////////////
    // cache ways
    ////////////////////

    // every way sees the same lookup and fill, only its fill bit differs
    for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
        icache_way u_way (
            .clock      (clock),
            .reset      (reset),
            .index      (line_index(pc)),
            .tag        (line_tag(pc)),
            .fill_en    (fill_way[g]),
            .fill_index (fill_index),
            .fill_tag   (fill_tag),
            .fill_line  (fill_line),
            .hit        (way_hit[g]),
            .line_data  (way_lines[g])
        );
    end

    icache_ctrl u_ctrl (
        .clock       (clock),
        .reset       (reset),
        .pc          (pc),
        .way_hit     (way_hit),
        .way_lines   (way_lines),
        .mem_valid   (mem_valid),
        .mem_data    (mem_data),
        .cache_valid (cache_valid),
        .cache_inst  (cache_inst),
        .fill_way    (fill_way),
        .fill_index  (fill_index),
        .fill_tag    (fill_tag),
        .fill_line   (fill_line),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr)
    );

endmodule

// File: icache_ctrl.sv
`timescale 1ns/1ns
`include "frontend_macros.svh"

module icache_ctrl import frontend_pkg::*; (
    input                                clock,
    input                                reset,
    // current fetch address
    input  addr_t                        pc,
    // per-way lookup results
    input  way_mask_t                    way_hit,
    input  line_t [`ICACHE_WAYS-1:0]     way_lines,
    // memory response
    input                                mem_valid,
    input  line_t                        mem_data,
    // toward the fetch stage
    output logic                         cache_valid,
    output inst_t                        cache_inst,
    // refill write, broadcast to all ways
    output way_mask_t                    fill_way,
    output index_t                       fill_index,
    output tag_t                         fill_tag,
    output line_t                        fill_line,
    // memory request
    output logic                         mem_req,
    output addr_t                        mem_addr
);

    typedef enum logic {
        S_IDLE,
        S_WAIT
    } state_t;

    state_t state;
    // line being fetched from memory
    index_t miss_index;
    tag_t   miss_tag;
    // one-hot victim pointer per set
    way_mask_t rr_ptr [`ICACHE_SETS];
    line_t     hit_line;
    logic      fill_fire;

    // rotate one-hot by one position, wraps for any way count
    function automatic way_mask_t rotate_one(way_mask_t m);
        return (m << 1) | (m >> (`ICACHE_WAYS - 1));
    endfunction

    ////////////////////
    // hit path
    ////////////////////

    // at most one way hits, so an or-mux is enough
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_line = hit_line | way_lines[w];
            end
        end
    end

    assign cache_valid = |way_hit;
    // pc bit 2 picks the upper or lower word of the line
    assign cache_inst  = pc[2] ? hit_line[63:32] : hit_line[31:0];

    ////////////////////
    // miss fsm
    ////////////////////

    // idle: look for a miss. wait: one request in flight
    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= S_IDLE;
            mem_req <= 1'b0;
        end else begin
            // single-cycle pulse by default
            mem_req <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (!cache_valid) begin
                        state   <= S_WAIT;
                        mem_req <= 1'b1;
                    end
                end
                S_WAIT: begin
                    // response writes the line this edge
                    if (mem_valid) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // capture the missing line when the request is issued
    always_ff @(posedge clock) begin
        if (state == S_IDLE && !cache_valid) begin
            miss_index <= line_index(pc);
            miss_tag   <= line_tag(pc);
        end
    end

    // request address stays stable while waiting
    assign mem_addr = line_addr(miss_tag, miss_index);

    ////////////////////
    // refill and victim
    ////////////////////

    // the response may still land after a redirect
    assign fill_fire  = (state == S_WAIT) && mem_valid;
    assign fill_way   = fill_fire ? rr_ptr[miss_index] : '0;
    assign fill_index = miss_index;
    assign fill_tag   = miss_tag;
    assign fill_line  = mem_data;

    // round robin per set, moves on every fill of that set
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                rr_ptr[s] <= way_mask_t'(1);
            end
        end else if (fill_fire) begin
            rr_ptr[miss_index] <= rotate_one(rr_ptr[miss_index]);
        end
    end

endmodule

// File: icache_way.sv
`timescale 1ns/1ns
`include "frontend_macros.svh"

module icache_way import frontend_pkg::*; (
    input               clock,
    input               reset,
    // lookup side, from the fetch pc
    input  index_t      index,
    input  tag_t        tag,
    // refill side, from the controller
    input               fill_en,
    input  index_t      fill_index,
    input  tag_t        fill_tag,
    input  line_t       fill_line,
    // lookup result
    output logic        hit,
    output line_t       line_data
);

    ////////////////////
    // storage
    ////////////////////

    // one valid bit per set
    logic [`ICACHE_SETS-1:0] valid;
    // tag and line arrays
    tag_t  tags  [`ICACHE_SETS];
    line_t lines [`ICACHE_SETS];

    // valid bits are the only state cleared on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[fill_index] <= 1'b1;
        end
    end

    // tag and data written together with the valid bit
    always_ff @(posedge clock) begin
        if (fill_en) begin
            tags[fill_index]  <= fill_tag;
            lines[fill_index] <= fill_line;
        end
    end

    ////////////////////
    // lookup
    ////////////////////

    // read is combinational, same cycle as pc
    assign hit       = valid[index] && (tags[index] == tag);
    // data goes out regardless, controller masks by hit
    assign line_data = lines[index];

endmodule

// File: run.sh
#!/bin/sh
# build and run the fetch frontend testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module frontend_tb -f vlog.f -o frontend_sim \
    && ./obj_dir/frontend_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run did not complete"; exit 1; }
cat sim.log
grep -qF '*** FAILED ***' sim.log && { echo "simulation failed"; exit 1; }
grep -qF '*** PASSED ***' sim.log || { echo "no verdict found in sim.log"; exit 1; }
echo "simulation passed"

// File: vlog.f
+incdir+.
frontend_pkg.sv
fetch_stage.sv
icache_way.sv
icache_ctrl.sv
frontend_top.sv
frontend_props.sv
frontend_tb.sv
